// ==== design/acq_pkg.sv ====
/*
 * acquisition control package
 * register map, control/status bit positions, vector types
 * and conversion timing constants shared by the core
 */

package acq_pkg;

   // ******************************
   // types
   // ******************************
   typedef logic [5:0]  apb_addr_t;  // register byte address
   typedef logic [31:0] apb_data_t;  // register data word
   typedef logic [5:0]  cycle_cnt_t; // position in one conversion, like the spi clk count
   typedef logic [15:0] frame_cnt_t; // chopper frames, period and change count

   // ******************************
   // register map
   // ******************************
   localparam apb_addr_t CTRL_ADDR   = 6'h00; // r/w
   localparam apb_addr_t STATUS_ADDR = 6'h04; // read only
   localparam apb_addr_t CHOP_ADDR   = 6'h08; // r/w, period | change count

   // control register bits
   localparam int STRG_BIT    = 0; // soft trigger
   localparam int CHOP_ON_BIT = 1; // chopper enable

   // status register bits
   localparam int ACQ_ON_BIT = 9;  // acquisition running
   localparam int CHOP_BIT   = 10; // live chopper level

   // chop register split, period on top
   localparam int CHOP_MAX_LSB = 16;

   // ******************************
   // conversion timing
   // ******************************
   localparam int CONV_CYCLES  = 40; // clocks per conversion
   localparam int CNVST_CYCLES = 4;  // convert strobe width at start of conversion

endpackage

// ==== design/acq_regs.sv ====
/*
 * acquisition register block
 * apb slave, no wait states, holding the control word and the
 * chopper period/change word; status word is built from live
 * acquisition and chopper state. bad accesses flag pslverr
 */

`timescale 1ns/1ps

module acq_regs (
   input  logic               adc_read_clk,
   input  logic               acqe_arst_sync, // active low
   // apb slave
   input  logic               psel_i,
   input  logic               penable_i,
   input  logic               pwrite_i,
   input  acq_pkg::apb_addr_t paddr_i,
   input  acq_pkg::apb_data_t pwdata_i,
   output acq_pkg::apb_data_t prdata_o,
   output logic               pready_o,
   output logic               pslverr_o,
   // live status
   input  logic               acq_on_i,
   input  logic               chop_i,
   // control out
   output logic               strg_o,
   output logic               chop_on_o,
   output acq_pkg::frame_cnt_t chop_max_o,
   output acq_pkg::frame_cnt_t chop_change_o
);

   localparam int FW = $bits(acq_pkg::frame_cnt_t);

   acq_pkg::apb_data_t ctrl_q;   // control word, full 32 bits kept
   acq_pkg::apb_data_t chop_q;   // period in top half, change count below
   acq_pkg::apb_data_t status_w;
   acq_pkg::apb_data_t rd_mux;

   logic access;
   logic ctrl_hit, status_hit, chop_hit;
   logic bad_acc;
   logic wr_en;

   // ******************************
   // address decode
   // ******************************
   assign access     = psel_i & penable_i; // access phase only
   assign ctrl_hit   = (paddr_i == acq_pkg::CTRL_ADDR);
   assign status_hit = (paddr_i == acq_pkg::STATUS_ADDR);
   assign chop_hit   = (paddr_i == acq_pkg::CHOP_ADDR);

   // unmapped, or write to the read-only status word
   assign bad_acc = access &
                    (~(ctrl_hit | status_hit | chop_hit) | (status_hit & pwrite_i));

   assign wr_en = access & pwrite_i & ~bad_acc;

   assign pready_o  = 1'b1;     // never stalls
   assign pslverr_o = bad_acc;

   // ******************************
   // registers
   // ******************************
   always_ff @(posedge adc_read_clk or negedge acqe_arst_sync) begin
      if (!acqe_arst_sync) begin
         ctrl_q <= '0;
         chop_q <= '0;
      end else begin
         if (wr_en && ctrl_hit) begin
            ctrl_q <= pwdata_i; // lands on the edge closing the access
         end
         if (wr_en && chop_hit) begin
            chop_q <= pwdata_i;
         end
      end
   end

   // status word, only two live bits
   always_comb begin
      status_w = '0;
      status_w[acq_pkg::ACQ_ON_BIT] = acq_on_i;
      status_w[acq_pkg::CHOP_BIT]   = chop_i;
   end

   // ******************************
   // read path
   // ******************************
   always_comb begin
      rd_mux = '0; // unmapped reads back zero
      if (ctrl_hit) begin
         rd_mux = ctrl_q;
      end else if (status_hit) begin
         rd_mux = status_w;
      end else if (chop_hit) begin
         rd_mux = chop_q;
      end
   end

   // valid in the access cycle of a read, zero otherwise
   assign prdata_o = (access && !pwrite_i) ? rd_mux : '0;

   // control fan-out
   assign strg_o        = ctrl_q[acq_pkg::STRG_BIT];
   assign chop_on_o     = ctrl_q[acq_pkg::CHOP_ON_BIT];
   assign chop_max_o    = chop_q[acq_pkg::CHOP_MAX_LSB +: FW]; // period
   assign chop_change_o = chop_q[0 +: FW];                     // change count

endmodule

// ==== design/acq_top.sv ====
/*
 * acquisition control core top
 * apb register block, soft trigger detect, conversion timer
 * and chopper, all on adc_read_clk
 */

`timescale 1ns/1ps

module acq_top (
   input  logic               adc_read_clk,
   input  logic               acqe_arst_sync, // active low
   // apb slave
   input  logic               psel_i,
   input  logic               penable_i,
   input  logic               pwrite_i,
   input  acq_pkg::apb_addr_t paddr_i,
   input  acq_pkg::apb_data_t pwdata_i,
   output acq_pkg::apb_data_t prdata_o,
   output logic               pready_o,
   output logic               pslverr_o,
   // adc side
   output logic               adc_cnvst_o,
   output logic               adc_chop_o,
   output logic               acq_on_o
);

   logic                strg;        // soft trigger bit
   logic                chop_on;     // chopper enable bit
   acq_pkg::frame_cnt_t chop_max;    // period
   acq_pkg::frame_cnt_t chop_change; // change count
   logic                frame_start;

   // ******************************
   // registers
   // ******************************
   acq_regs i_acq_regs (
      .adc_read_clk   (adc_read_clk),
      .acqe_arst_sync (acqe_arst_sync),
      .psel_i         (psel_i),
      .penable_i      (penable_i),
      .pwrite_i       (pwrite_i),
      .paddr_i        (paddr_i),
      .pwdata_i       (pwdata_i),
      .prdata_o       (prdata_o),
      .pready_o       (pready_o),
      .pslverr_o      (pslverr_o),
      .acq_on_i       (acq_on_o),   // status readback
      .chop_i         (adc_chop_o), // status readback
      .strg_o         (strg),
      .chop_on_o      (chop_on),
      .chop_max_o     (chop_max),
      .chop_change_o  (chop_change)
   );

   // trigger generation
   acq_trigger i_acq_trigger (
      .adc_read_clk   (adc_read_clk),
      .acqe_arst_sync (acqe_arst_sync),
      .strg_i         (strg),
      .acq_on_o       (acq_on_o)
   );

   // ******************************
   // conversion pacing
   // ******************************
   conv_timer i_conv_timer (
      .adc_read_clk   (adc_read_clk),
      .acqe_arst_sync (acqe_arst_sync),
      .cnvst_o        (adc_cnvst_o),
      .frame_start_o  (frame_start)
   );

   chop_gen i_chop_gen (
      .adc_read_clk   (adc_read_clk),
      .acqe_arst_sync (acqe_arst_sync),
      .frame_start_i  (frame_start),
      .chop_on_i      (chop_on),
      .chop_max_i     (chop_max),
      .chop_change_i  (chop_change),
      .chop_o         (adc_chop_o)
   );

endmodule

// ==== design/acq_trigger.sv ====
/*
 * software trigger edge detect
 * two stage delay pipe on the soft trigger bit; a rising
 * edge sets the acquisition-on flag until the next reset
 */

`timescale 1ns/1ps

module acq_trigger (
   input  logic adc_read_clk,
   input  logic acqe_arst_sync, // active low
   input  logic strg_i,         // soft trigger, from control word
   output logic acq_on_o
);

   logic [1:0] soft_trig_dly; // [1] older, [0] newer

   always_ff @(posedge adc_read_clk or negedge acqe_arst_sync) begin
      if (!acqe_arst_sync) begin
         // ones, so a trigger already high at release is ignored
         soft_trig_dly <= 2'b11;
         acq_on_o      <= 1'b0;
      end else begin
         soft_trig_dly <= {soft_trig_dly[0], strg_i}; // delay pipe

         // 0 then 1 seen, rising edge
         if (soft_trig_dly == 2'b01) begin
            acq_on_o <= 1'b1; // sticky
         end
      end
   end

endmodule

// ==== design/chop_gen.sv ====
/*
 * chopper generator
 * counts conversion frames up to the programmed period and
 * holds the chop output high while the count is below the
 * change count, so change/period sets the duty cycle
 */

`timescale 1ns/1ps

module chop_gen (
   input  logic                adc_read_clk,
   input  logic                acqe_arst_sync, // active low
   input  logic                frame_start_i,  // once per conversion
   input  logic                chop_on_i,
   input  acq_pkg::frame_cnt_t chop_max_i,     // period in frames
   input  acq_pkg::frame_cnt_t chop_change_i,  // frames high per period
   output logic                chop_o
);

   acq_pkg::frame_cnt_t frame_cnt;
   logic                frame_wrap;

   // ******************************
   // period wrap
   // ******************************
   // zero period parks the count at 0
   // >= also catches a period lowered under the running count
   assign frame_wrap = (chop_max_i == '0) ||
                       (frame_cnt >= chop_max_i - acq_pkg::frame_cnt_t'(1));

   always_ff @(posedge adc_read_clk or negedge acqe_arst_sync) begin
      if (!acqe_arst_sync) begin
         frame_cnt <= '0;
         chop_o    <= 1'b0;
      end else if (!chop_on_i) begin
         frame_cnt <= '0;   // disabled, parked
         chop_o    <= 1'b0;
      end else if (frame_start_i) begin
         // level for this frame from the current count
         chop_o <= (frame_cnt < chop_change_i);

         if (frame_wrap) begin
            frame_cnt <= '0;
         end else begin
            frame_cnt <= frame_cnt + 1'b1;
         end
      end
   end

endmodule

// ==== design/conv_timer.sv ====
/*
 * conversion cycle timer
 * free running count modulo CONV_CYCLES; registered convert
 * strobe over the first CNVST_CYCLES counts, frame start pulse
 * while the count sits at 0
 */

`timescale 1ns/1ps

module conv_timer (
   input  logic adc_read_clk,
   input  logic acqe_arst_sync, // active low
   output logic cnvst_o,        // adc convert strobe
   output logic frame_start_o   // one cycle, count == 0
);

   localparam acq_pkg::cycle_cnt_t LAST_CNT = acq_pkg::cycle_cnt_t'(acq_pkg::CONV_CYCLES - 1);

   acq_pkg::cycle_cnt_t cycle_cnt;
   acq_pkg::cycle_cnt_t cycle_cnt_nxt;

   // wrap at end of conversion
   assign cycle_cnt_nxt = (cycle_cnt == LAST_CNT) ? '0 : cycle_cnt + 1'b1;

   always_ff @(posedge adc_read_clk or negedge acqe_arst_sync) begin
      if (!acqe_arst_sync) begin
         cycle_cnt <= LAST_CNT; // first edge out of reset opens a full conversion
         cnvst_o   <= 1'b0;
      end else begin
         cycle_cnt <= cycle_cnt_nxt;
         // strobe follows the count it belongs to
         cnvst_o   <= (cycle_cnt_nxt < acq_pkg::CNVST_CYCLES);
      end
   end

   assign frame_start_o = (cycle_cnt == '0);

endmodule

// ==== dv/acq_tb.sv ====
/*
 * acquisition core testbench
 * vector driven apb register, slave error, soft trigger,
 * convert strobe and chopper pattern checks on acq_top
 */

`timescale 1ns/1ps

module acq_tb;

   logic               adc_read_clk;
   logic               acqe_arst_sync;
   logic               psel, penable, pwrite;
   acq_pkg::apb_addr_t paddr;
   acq_pkg::apb_data_t pwdata;
   acq_pkg::apb_data_t prdata;
   logic               pready, pslverr;
   logic               adc_cnvst, adc_chop, acq_on;

   logic [31:0] lfsr = 32'h2210;
   int cycles = 0;
   int limit = 0;     // 0 until the vector file is read

   // strobe monitor state
   int   rise_cnt = 0;
   int   since_rise = 0;
   int   high_cnt = 0;
   int   last_gap, last_width;
   logic cnvst_prev = 1'b0;
   logic chop_at_rise, chop_at_read;

   // parsed vector lines
   logic [7:0]  op_q[$];
   string       name_q[$];
   logic [31:0] a_q[$], b_q[$], c_q[$], d_q[$];

   acq_top i_acq_top (
      .adc_read_clk   (adc_read_clk),
      .acqe_arst_sync (acqe_arst_sync),
      .psel_i         (psel),
      .penable_i      (penable),
      .pwrite_i       (pwrite),
      .paddr_i        (paddr),
      .pwdata_i       (pwdata),
      .prdata_o       (prdata),
      .pready_o       (pready),
      .pslverr_o      (pslverr),
      .adc_cnvst_o    (adc_cnvst),
      .adc_chop_o     (adc_chop),
      .acq_on_o       (acq_on)
   );

   always #4 adc_read_clk = ~adc_read_clk; // 8 ns period

   // ******************************
   // timeout and strobe monitor
   // ******************************
   always @(negedge adc_read_clk) begin
      cycles++;
      if (limit > 0 && cycles > limit) begin
         $display("timeout after %0d cycles, tests did not complete", cycles);
         stop_with_failure();
      end
   end

   // outputs are posedge driven, so stable here
   always @(negedge adc_read_clk) begin
      since_rise++;
      if (adc_cnvst && !cnvst_prev) begin
         last_gap     = since_rise; // cycles since previous rise
         last_width   = high_cnt;   // width of previous strobe
         chop_at_rise = adc_chop;
         since_rise   = 0;
         high_cnt     = 1;
         rise_cnt++;
      end else if (adc_cnvst) begin
         high_cnt++;
      end
      cnvst_prev = adc_cnvst;
   end

   // taps 32 22 2 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic next_rand(input int nbits, output logic [31:0] val);
      val = '0;
      for (int i = 0; i < nbits; i++) begin
         lfsr = lfsr_step(lfsr); // one step per bit
         val  = {val[30:0], lfsr[0]};
      end
   endtask

   task automatic stop_with_failure();
      $display("FAIL: see errors above");
      $fatal(1);
   endtask

   // ******************************
   // compare tasks
   // ******************************
   task automatic check_data(input string name, input acq_pkg::apb_data_t exp,
                             input acq_pkg::apb_data_t act);
      if (act !== exp) begin
         $display("FAILED %s: expected %h, actual %h", name, exp, act);
         stop_with_failure();
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("FAILED %s: expected %b, actual %b", name, exp, act);
         stop_with_failure();
      end
   endtask

   task automatic check_frames(input string name, input acq_pkg::frame_cnt_t exp,
                               input acq_pkg::frame_cnt_t act);
      if (act !== exp) begin
         $display("FAILED %s: expected %0d, actual %0d", name, exp, act);
         stop_with_failure();
      end
   endtask

   task automatic check_cycles(input string name, input acq_pkg::cycle_cnt_t exp,
                               input acq_pkg::cycle_cnt_t act);
      if (act !== exp) begin
         $display("FAILED %s: expected %0d cycles, actual %0d", name, exp, act);
         stop_with_failure();
      end
   endtask

   // ******************************
   // apb driver
   // ******************************
   // entered and left on a falling edge
   task automatic apb_xfer(input logic wr, input acq_pkg::apb_addr_t addr,
                           input acq_pkg::apb_data_t wdata,
                           output acq_pkg::apb_data_t rdata, output logic err);
      logic [31:0] gap;
      next_rand(2, gap);
      repeat (gap) @(negedge adc_read_clk); // idle 0..3
      psel    = 1'b1;                        // setup
      penable = 1'b0;
      pwrite  = wr;
      paddr   = addr;
      pwdata  = wdata;
      @(negedge adc_read_clk);
      penable = 1'b1;                        // access
      #2;
      rdata        = prdata;
      err          = pslverr;
      chop_at_read = adc_chop;
      check_bit("apb_pready", 1'b1, pready);
      @(negedge adc_read_clk);
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic trigger_check(input string name);
      acq_pkg::apb_data_t rd;
      logic               err;
      logic [31:0]        junk;
      int                 n;
      check_bit(name, 1'b0, acq_on); // nothing fired yet
      apb_xfer(1'b0, acq_pkg::STATUS_ADDR, '0, rd, err);
      check_bit(name, 1'b0, rd[acq_pkg::ACQ_ON_BIT]);
      next_rand(30, junk);
      apb_xfer(1'b1, acq_pkg::CTRL_ADDR, {junk[29:0], 2'b01}, rd, err); // strg up
      n = 0;
      while (!acq_on && n < 4) begin
         @(negedge adc_read_clk);
         n++;
      end
      check_bit(name, 1'b1, acq_on);
      apb_xfer(1'b1, acq_pkg::CTRL_ADDR, {junk[29:0], 2'b00}, rd, err); // strg down
      repeat (4) @(negedge adc_read_clk);
      check_bit(name, 1'b1, acq_on); // sticky
      apb_xfer(1'b0, acq_pkg::STATUS_ADDR, '0, rd, err);
      check_bit(name, 1'b1, rd[acq_pkg::ACQ_ON_BIT]);
   endtask

   task automatic chop_check(input string name, input acq_pkg::frame_cnt_t period,
                             input acq_pkg::frame_cnt_t change, input int frames,
                             input logic en);
      acq_pkg::apb_data_t  rd;
      logic                err;
      logic [31:0]         junk;
      logic                smp[$];
      acq_pkg::frame_cnt_t highs, exp_highs, rises, exp_rises;
      int                  n;
      next_rand(30, junk);
      apb_xfer(1'b1, acq_pkg::CTRL_ADDR, {junk[29:0], 2'b00}, rd, err); // park
      apb_xfer(1'b1, acq_pkg::CHOP_ADDR, {period, change}, rd, err);
      apb_xfer(1'b1, acq_pkg::CTRL_ADDR, {junk[29:0], en, 1'b0}, rd, err);
      @(negedge adc_read_clk);
      n = rise_cnt;
      repeat (frames + 1) begin
         while (rise_cnt == n) @(negedge adc_read_clk);
         n = rise_cnt;
         smp.push_back(chop_at_rise);
         check_cycles(name, acq_pkg::CONV_CYCLES, last_gap);
         check_cycles(name, acq_pkg::CNVST_CYCLES, last_width);
      end
      smp.delete(0); // may still show the old setting
      exp_highs = (change > period) ? period : change;
      if (!en) begin
         exp_highs = '0;
      end
      // equal sliding sums also force the pattern to repeat each period
      for (int i = 0; i + period <= frames; i++) begin
         highs = '0;
         for (int j = 0; j < period; j++) begin
            highs += smp[i + j];
         end
         check_frames(name, exp_highs, highs); // highs per window
      end
      rises = '0;
      for (int j = 0; j < period; j++) begin
         if (smp[j] && !smp[(j + period - 1) % period]) begin
            rises++;
         end
      end
      exp_rises = (exp_highs > 0 && exp_highs < period) ? 1 : 0;
      check_frames(name, exp_rises, rises); // one contiguous run
      apb_xfer(1'b0, acq_pkg::STATUS_ADDR, '0, rd, err);
      check_bit(name, chop_at_read, rd[acq_pkg::CHOP_BIT]);
   endtask

   // ******************************
   // main sequence
   // ******************************
   initial begin
      int                 fd;
      int                 sum;
      string              line;
      logic [7:0]         op;
      logic [255:0]       nm;
      logic [31:0]        a, b, c, d;
      acq_pkg::apb_data_t rd;
      logic               err;
      adc_read_clk   = 1'b0;
      acqe_arst_sync = 1'b0;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = '0;
      pwdata  = '0;
      fd = $fopen("dv/acq_tests.txt", "r");
      if (fd == 0) begin
         $display("cannot open the vector file dv/acq_tests.txt");
         stop_with_failure();
      end
      sum = 0;
      while ($fgets(line, fd) > 0) begin
         if (line.len() > 1 && line.getc(0) != "#") begin
            a = '0;
            b = '0;
            c = '0;
            d = '0;
            void'($sscanf(line, "%s %s %h %h %h %h", op, nm, a, b, c, d));
            op_q.push_back(op);
            name_q.push_back(string'(nm));
            a_q.push_back(a);
            b_q.push_back(b);
            c_q.push_back(c);
            d_q.push_back(d);
            sum += 20;
            if (op == "C") begin
               sum += (c + 2) * acq_pkg::CONV_CYCLES; // frames plus margin
            end
         end
      end
      $fclose(fd);
      limit = sum;
      repeat (2) @(negedge adc_read_clk);
      acqe_arst_sync = 1'b1;
      foreach (op_q[k]) begin
         case (op_q[k])
            "W": begin
               apb_xfer(1'b1, a_q[k][5:0], b_q[k], rd, err);
               check_bit(name_q[k], 1'b0, err);
            end
            "R": begin
               apb_xfer(1'b0, a_q[k][5:0], '0, rd, err);
               check_bit(name_q[k], 1'b0, err);
               check_data(name_q[k], b_q[k], rd);
            end
            "E": begin
               apb_xfer(b_q[k][0], a_q[k][5:0], c_q[k], rd, err);
               check_bit(name_q[k], 1'b1, err);
               check_data(name_q[k], '0, rd);
            end
            "C": chop_check(name_q[k], a_q[k][15:0], b_q[k][15:0], c_q[k], d_q[k][0]);
            "T": trigger_check(name_q[k]);
            default: begin
               $display("unknown operation in vector line %s", name_q[k]);
               stop_with_failure();
            end
         endcase
      end
      $display("PASS: all tests");
      $finish;
   end

endmodule

// ==== dv/acq_tests.txt ====
# columns: op name arg1 arg2 arg3 arg4, args in hex
# W addr data | R addr expected | E addr write data | C period change frames enable | T
R rst_ctrl 00 00000000
R rst_status 04 00000000
R rst_chop 08 00000000
W ctrl_upper_wr 00 a5a5a5a4
R ctrl_upper_rd 00 a5a5a5a4
W chop_wr 08 00050002
R chop_rd 08 00050002
E unmapped_rd 0c 0 00000000
E unmapped_wr 3c 1 ffffffff
E status_wr 04 1 ffffffff
R status_unchanged 04 00000000
R ctrl_unchanged 00 a5a5a5a4
R chop_unchanged 08 00050002
T soft_trigger
R status_acq_on 04 00000200
C chop_4_1 4 1 c 1
C chop_5_2 5 2 f 1
C chop_3_3 3 3 9 1
C chop_8_0 8 0 10 1
C chop_off 4 2 8 0
R chop_last 08 00040002

// ==== list.f ====
design/acq_pkg.sv
design/acq_regs.sv
design/acq_trigger.sv
design/conv_timer.sv
design/chop_gen.sv
design/acq_top.sv
dv/acq_tb.sv

// ==== run.sh ====
#!/bin/sh
# build acq_tb with verilator and run it from the project root
cd "$(dirname "$0")" \
   && verilator --binary --timing -Wno-fatal -f list.f --top-module acq_tb -o acq_sim \
   && ./obj_dir/acq_sim | tee /dev/stderr | grep -q "PASS: all tests" \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }
